// File: coproc_pkg.sv
// Shared widths and encodings; a slot holds one field element and the header fits in one element
package coproc_pkg;

  localparam int FE_BITS        = 16;
  localparam int SLOT_ADDR_BITS = 8;
  localparam int INST_ADDR_BITS = 8;
  localparam int INST_BITS      = 28;

  typedef logic [FE_BITS-1:0]        fe_t;
  typedef logic [SLOT_ADDR_BITS-1:0] slot_addr_t;
  typedef logic [INST_ADDR_BITS-1:0] inst_addr_t;
  typedef logic [INST_BITS-1:0]      inst_t;

  // Instruction word is {opcode, a, b, c}
  localparam int OP_BITS    = 4;
  localparam int FIELD_BITS = 8;
  localparam int OP_LSB     = 24;
  localparam int A_LSB      = 16;
  localparam int B_LSB      = 8;
  localparam int C_LSB      = 0;

  // Interrupt header word {tag, count}
  localparam int HDR_TAG_LSB = 8;
  localparam int HDR_CNT_LSB = 0;

  // Unlisted codes decode as NOOP_WAIT
  typedef enum logic [OP_BITS-1:0] {
    NOOP_WAIT      = 4'd0,
    COPY_REG       = 4'd1,
    ADD_ELEMENT    = 4'd2,
    SUB_ELEMENT    = 4'd3,
    MUL_ELEMENT    = 4'd4,
    SEND_INTERRUPT = 4'd5
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_MUL
  } alu_op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,     // Waiting for the instruction word
    S_RD_A,
    S_RD_B,
    S_ALU,
    S_HDR,       // Offering the interrupt header
    S_SEND_RD,
    S_SEND_OUT
  } seq_state_e;

endpackage

// File: coproc_top.sv
// Load ports must not be written while a program runs, and i_start is ignored while o_busy is high
module coproc_top
  import coproc_pkg::*;
#(
  parameter int unsigned P = 65521
)(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_inst_we,
  input  inst_addr_t i_inst_addr,
  input  inst_t      i_inst_dat,
  input  logic       i_slot_we,
  input  slot_addr_t i_slot_addr,
  input  fe_t        i_slot_dat,
  input  logic       i_start,
  input  inst_addr_t i_start_pt,
  output logic       o_busy,
  output logic       o_tx_val,
  output fe_t        o_tx_dat,
  output logic       o_tx_sop,
  output logic       o_tx_eop,
  input  logic       i_tx_rdy
);

  logic       fetch_req, jump, inst_val;
  inst_addr_t jump_pt;
  inst_t      inst;
  logic       rd_en, rd_val, wr_en;
  slot_addr_t rd_addr, wr_addr;
  fe_t        rd_dat, wr_dat;
  logic       alu_go, alu_done;
  alu_op_e    alu_op;
  fe_t        alu_a, alu_b, alu_res;
  logic       word_val, word_sop, word_eop, tx_full;
  fe_t        word;

  inst_fetch inst_fetch_inst (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_we       (i_inst_we),
    .i_waddr    (i_inst_addr),
    .i_wdat     (i_inst_dat),
    .i_req      (fetch_req),
    .i_jump     (jump),
    .i_jump_pt  (jump_pt),
    .o_inst_val (inst_val),
    .o_inst     (inst)
  );

  slot_ram slot_ram_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ld_we   (i_slot_we),
    .i_ld_addr (i_slot_addr),
    .i_ld_dat  (i_slot_dat),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_val  (rd_val),
    .o_rd_dat  (rd_dat),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_dat  (wr_dat)
  );

  inst_sequencer inst_sequencer_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (i_start),
    .i_start_pt  (i_start_pt),
    .o_busy      (o_busy),
    .o_fetch_req (fetch_req),
    .o_jump      (jump),
    .o_jump_pt   (jump_pt),
    .i_inst_val  (inst_val),
    .i_inst      (inst),
    .o_rd_en     (rd_en),
    .o_rd_addr   (rd_addr),
    .i_rd_val    (rd_val),
    .i_rd_dat    (rd_dat),
    .o_wr_en     (wr_en),
    .o_wr_addr   (wr_addr),
    .o_wr_dat    (wr_dat),
    .o_alu_go    (alu_go),
    .o_alu_op    (alu_op),
    .o_alu_a     (alu_a),
    .o_alu_b     (alu_b),
    .i_alu_done  (alu_done),
    .i_alu_res   (alu_res),
    .o_word_val  (word_val),
    .o_word      (word),
    .o_word_sop  (word_sop),
    .o_word_eop  (word_eop),
    .i_tx_full   (tx_full)
  );

  fe_alu #(
    .P (P)
  ) fe_alu_inst (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_go   (alu_go),
    .i_op   (alu_op),
    .i_a    (alu_a),
    .i_b    (alu_b),
    .o_done (alu_done),
    .o_res  (alu_res)
  );

  interrupt_tx interrupt_tx_inst (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_val    (word_val),
    .i_dat    (word),
    .i_sop    (word_sop),
    .i_eop    (word_eop),
    .o_full   (tx_full),
    .o_tx_val (o_tx_val),
    .o_tx_dat (o_tx_dat),
    .o_tx_sop (o_tx_sop),
    .o_tx_eop (o_tx_eop),
    .i_tx_rdy (i_tx_rdy)
  );

endmodule

// File: fe_alu.sv
// P must be odd and below 2**FE_BITS and operands must already be reduced below P
module fe_alu
  import coproc_pkg::*;
#(
  parameter int unsigned P = 65521
)(
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_go,
  input  alu_op_e i_op,
  input  fe_t     i_a,
  input  fe_t     i_b,
  output logic    o_done,
  output fe_t     o_res
);

  localparam int CNT_BITS = $clog2(FE_BITS+1);
  localparam fe_t P_FE = fe_t'(P);
  localparam logic [FE_BITS:0] P_EXT = {1'b0, P_FE};

  logic                mul_busy;
  logic [CNT_BITS-1:0] cnt;
  fe_t                 a_q, b_q, acc;
  logic [FE_BITS:0]    add_sum, mul_sum;
  fe_t                 mul_dbl, mul_next;

  // One conditional subtraction for an input below 2P
  function automatic fe_t mod_red(input logic [FE_BITS:0] x);
    logic [FE_BITS:0] y;
    y = x - P_EXT;
    return (x >= P_EXT) ? y[FE_BITS-1:0] : x[FE_BITS-1:0];
  endfunction

  always_comb begin
    add_sum  = {1'b0, i_a} + {1'b0, i_b};
    mul_dbl  = mod_red({acc, 1'b0});
    mul_sum  = {1'b0, mul_dbl} + (b_q[FE_BITS-1] ? {1'b0, a_q} : '0); // MSB first
    mul_next = mod_red(mul_sum);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_done   <= 1'b0;
      mul_busy <= 1'b0;
      cnt      <= '0;
    end else begin
      o_done <= 1'b0;
      if (i_go) begin
        if (i_op == ALU_MUL) begin
          mul_busy <= 1'b1;
          cnt      <= CNT_BITS'(FE_BITS);
        end else begin
          o_done <= 1'b1;
        end
      end else if (mul_busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == 1) begin
          mul_busy <= 1'b0;
          o_done   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_go) begin
      a_q <= i_a;
      b_q <= i_b;
      acc <= '0;
      if (i_op == ALU_ADD) begin
        o_res <= mod_red(add_sum);
      end else if (i_op == ALU_SUB) begin
        o_res <= (i_a >= i_b) ? i_a - i_b : i_a - i_b + P_FE; // Wraps back into range
      end
    end else if (mul_busy) begin
      acc <= mul_next;
      b_q <= b_q << 1;
      if (cnt == 1) begin
        o_res <= mul_next;
      end
    end
  end

endmodule

// File: inst_fetch.sv
// Instruction comes out exactly 2 cycles after i_req and a load to the fetched address in between is not seen
module inst_fetch
  import coproc_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_we,
  input  inst_addr_t i_waddr,
  input  inst_t      i_wdat,
  input  logic       i_req,
  input  logic       i_jump,
  input  inst_addr_t i_jump_pt,
  output logic       o_inst_val,
  output inst_t      o_inst
);

  inst_t      mem [0:2**INST_ADDR_BITS-1];
  inst_addr_t ptr;
  inst_addr_t next_pt;
  inst_t      rd_q;
  logic [1:0] val_sr;

  assign next_pt    = i_jump ? i_jump_pt : ptr + 1'b1;
  assign o_inst_val = val_sr[1];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdat;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr    <= '0;
      val_sr <= '0;
    end else begin
      val_sr <= {val_sr[0], i_req};
      if (i_req) begin
        ptr <= next_pt;
      end
    end
  end

  // Two read stages to match block RAM output register
  always_ff @(posedge i_clk) begin
    if (i_req) begin
      rd_q <= mem[next_pt];
    end
    o_inst <= rd_q;
  end

endmodule

// File: inst_sequencer.sv
// One instruction in flight, i_start is only taken in idle and interrupt words wait for i_tx_full low
module inst_sequencer
  import coproc_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_start,
  input  inst_addr_t i_start_pt,
  output logic       o_busy,
  output logic       o_fetch_req,
  output logic       o_jump,
  output inst_addr_t o_jump_pt,
  input  logic       i_inst_val,
  input  inst_t      i_inst,
  output logic       o_rd_en,
  output slot_addr_t o_rd_addr,
  input  logic       i_rd_val,
  input  fe_t        i_rd_dat,
  output logic       o_wr_en,
  output slot_addr_t o_wr_addr,
  output fe_t        o_wr_dat,
  output logic       o_alu_go,
  output alu_op_e    o_alu_op,
  output fe_t        o_alu_a,
  output fe_t        o_alu_b,
  input  logic       i_alu_done,
  input  fe_t        i_alu_res,
  output logic       o_word_val,
  output fe_t        o_word,
  output logic       o_word_sop,
  output logic       o_word_eop,
  input  logic       i_tx_full
);

  seq_state_e            state;
  inst_t                 inst_q;
  opcode_e               new_op, cur_op;
  slot_addr_t            fld_b, fld_c;
  fe_t                   hdr, word_q;
  slot_addr_t            send_ptr;
  logic [FIELD_BITS-1:0] send_cnt;  // Slots still to send

  assign new_op = opcode_e'(i_inst[OP_LSB +: OP_BITS]);
  assign cur_op = opcode_e'(inst_q[OP_LSB +: OP_BITS]);
  assign fld_b  = inst_q[B_LSB +: FIELD_BITS];
  assign fld_c  = inst_q[C_LSB +: FIELD_BITS];

  always_comb begin
    hdr = '0;
    hdr[HDR_TAG_LSB +: FIELD_BITS] = fld_b;
    hdr[HDR_CNT_LSB +: FIELD_BITS] = fld_c;
  end

  assign o_busy     = (state != S_IDLE);
  assign o_word_val = (state == S_HDR || state == S_SEND_OUT) && !i_tx_full;
  assign o_word     = (state == S_HDR) ? hdr : word_q;
  assign o_word_sop = (state == S_HDR);
  assign o_word_eop = (state == S_HDR) ? (fld_c == '0) : (send_cnt == 1);

  // Current instruction is finished, ask for the one after it
  task automatic next_inst();
    o_fetch_req <= 1'b1;
    o_jump      <= 1'b0;
    state       <= S_FETCH;
  endtask

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= S_IDLE;
      o_fetch_req <= 1'b0;
      o_jump      <= 1'b0;
      o_rd_en     <= 1'b0;
      o_wr_en     <= 1'b0;
      o_alu_go    <= 1'b0;
      send_cnt    <= '0;
      send_ptr    <= '0;
    end else begin
      o_fetch_req <= 1'b0;
      o_rd_en     <= 1'b0;
      o_wr_en     <= 1'b0;
      o_alu_go    <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            o_fetch_req <= 1'b1;
            o_jump      <= 1'b1;
            o_jump_pt   <= i_start_pt;
            state       <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (i_inst_val) begin
            inst_q    <= i_inst;
            o_rd_addr <= i_inst[A_LSB +: FIELD_BITS];
            send_ptr  <= i_inst[A_LSB +: FIELD_BITS];
            send_cnt  <= i_inst[C_LSB +: FIELD_BITS];
            case (new_op)
              COPY_REG, ADD_ELEMENT, SUB_ELEMENT, MUL_ELEMENT: begin
                o_rd_en <= 1'b1;
                state   <= S_RD_A;
              end
              SEND_INTERRUPT: state <= S_HDR;
              default: state <= S_IDLE;  // NOOP_WAIT halts until next start
            endcase
          end
        end
        S_RD_A: begin
          if (i_rd_val) begin
            o_alu_a <= i_rd_dat;
            if (cur_op == COPY_REG) begin
              o_wr_en   <= 1'b1;
              o_wr_addr <= fld_b;
              o_wr_dat  <= i_rd_dat;
              next_inst();
            end else begin
              o_rd_en   <= 1'b1;
              o_rd_addr <= fld_b;
              state     <= S_RD_B;
            end
          end
        end
        S_RD_B: begin
          if (i_rd_val) begin
            o_alu_go <= 1'b1;
            o_alu_b  <= i_rd_dat;
            o_alu_op <= (cur_op == ADD_ELEMENT) ? ALU_ADD :
                        (cur_op == SUB_ELEMENT) ? ALU_SUB : ALU_MUL;
            state    <= S_ALU;
          end
        end
        S_ALU: begin
          if (i_alu_done) begin
            o_wr_en   <= 1'b1;
            o_wr_addr <= fld_c;
            o_wr_dat  <= i_alu_res;
            next_inst();
          end
        end
        S_HDR: begin
          if (o_word_val) begin
            if (send_cnt == '0) begin
              next_inst();
            end else begin
              o_rd_en   <= 1'b1;
              o_rd_addr <= send_ptr;
              state     <= S_SEND_RD;
            end
          end
        end
        S_SEND_RD: begin
          if (i_rd_val) begin
            word_q   <= i_rd_dat;
            send_ptr <= send_ptr + 1'b1;
            state    <= S_SEND_OUT;
          end
        end
        S_SEND_OUT: begin
          if (o_word_val) begin
            send_cnt <= send_cnt - 1'b1;
            if (send_cnt == 1) begin
              next_inst();
            end else begin
              o_rd_en   <= 1'b1;
              o_rd_addr <= send_ptr;
              state     <= S_SEND_RD;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: interrupt_tx.sv
// Single word buffer where the source may offer a word only while o_full is low
module interrupt_tx
  import coproc_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_val,
  input  fe_t  i_dat,
  input  logic i_sop,
  input  logic i_eop,
  output logic o_full,
  output logic o_tx_val,
  output fe_t  o_tx_dat,
  output logic o_tx_sop,
  output logic o_tx_eop,
  input  logic i_tx_rdy
);

  // Register frees up in the same cycle it is accepted
  assign o_full = o_tx_val && !i_tx_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tx_val <= 1'b0;
      o_tx_sop <= 1'b0;
      o_tx_eop <= 1'b0;
    end else if (i_val && !o_full) begin
      o_tx_val <= 1'b1;
      o_tx_sop <= i_sop;
      o_tx_eop <= i_eop;
    end else if (i_tx_rdy) begin
      o_tx_val <= 1'b0;
      o_tx_sop <= 1'b0;
      o_tx_eop <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_val && !o_full) begin
      o_tx_dat <= i_dat;  // Held stable until taken
    end
  end

endmodule

// File: slot_ram.sv
// Read data is valid 2 cycles after i_rd_en and a user load takes the write port over a sequencer write
module slot_ram
  import coproc_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_ld_we,
  input  slot_addr_t i_ld_addr,
  input  fe_t        i_ld_dat,
  input  logic       i_rd_en,
  input  slot_addr_t i_rd_addr,
  output logic       o_rd_val,
  output fe_t        o_rd_dat,
  input  logic       i_wr_en,
  input  slot_addr_t i_wr_addr,
  input  fe_t        i_wr_dat
);

  fe_t        mem [0:2**SLOT_ADDR_BITS-1];
  fe_t        rd_q;
  logic [1:0] val_sr;

  assign o_rd_val = val_sr[1];

  always_ff @(posedge i_clk) begin
    if (i_ld_we) begin
      mem[i_ld_addr] <= i_ld_dat;
    end else if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_dat;
    end
    if (i_rd_en) begin
      rd_q <= mem[i_rd_addr];
    end
    o_rd_dat <= rd_q;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_sr <= '0;
    end else begin
      val_sr <= {val_sr[0], i_rd_en};
    end
  end

endmodule

// File: src.f
coproc_pkg.sv
inst_fetch.sv
slot_ram.sv
fe_alu.sv
inst_sequencer.sv
interrupt_tx.sv
coproc_top.sv
tb_coproc.sv

// File: tb_coproc.sv
// Runs with the default 16-bit field and P of 65521, and loads memories only while the DUT is idle
module tb_coproc
  import coproc_pkg::*;
();

  localparam int unsigned P = 65521;
  localparam int TOTAL_INSTS = 21;  // Sum of all program lengths below
  localparam int WATCHDOG_CYCLES = 4 * TOTAL_INSTS * (FE_BITS + 20) + 500;

  logic       i_clk;
  logic       i_rst;
  logic       i_inst_we;
  inst_addr_t i_inst_addr;
  inst_t      i_inst_dat;
  logic       i_slot_we;
  slot_addr_t i_slot_addr;
  fe_t        i_slot_dat;
  logic       i_start;
  inst_addr_t i_start_pt;
  logic       o_busy;
  logic       o_tx_val;
  fe_t        o_tx_dat;
  logic       o_tx_sop;
  logic       o_tx_eop;
  logic       i_tx_rdy;

  integer seed;
  int     checks;
  int     errors;
  fe_t    opnd [0:7];
  string  cur_test;

  fe_t  got_dat [$];
  logic got_sop [$];
  logic got_eop [$];
  fe_t  exp_dat [$];
  logic exp_sop [$];
  logic exp_eop [$];

  logic hold_pending;
  fe_t  held_dat;

  coproc_top #(
    .P (P)
  ) coproc_top_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_inst_we   (i_inst_we),
    .i_inst_addr (i_inst_addr),
    .i_inst_dat  (i_inst_dat),
    .i_slot_we   (i_slot_we),
    .i_slot_addr (i_slot_addr),
    .i_slot_dat  (i_slot_dat),
    .i_start     (i_start),
    .i_start_pt  (i_start_pt),
    .o_busy      (o_busy),
    .o_tx_val    (o_tx_val),
    .o_tx_dat    (o_tx_dat),
    .o_tx_sop    (o_tx_sop),
    .o_tx_eop    (o_tx_eop),
    .i_tx_rdy    (i_tx_rdy)
  );

  initial i_clk = 1'b0;
  always #50 i_clk = ~i_clk;

  // Collects accepted words and checks that a waiting word stays put
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (hold_pending) begin
        checks++;
        assert (o_tx_val && o_tx_dat == held_dat) else begin
          $display("FAILED %s hold: expected %h, actual %h (valid %b)",
                   cur_test, held_dat, o_tx_dat, o_tx_val);
          errors++;
        end
      end
      if (o_tx_val && i_tx_rdy) begin
        got_dat.push_back(o_tx_dat);
        got_sop.push_back(o_tx_sop);
        got_eop.push_back(o_tx_eop);
      end
      hold_pending = o_tx_val && !i_tx_rdy;
      held_dat     = o_tx_dat;
    end
  end

  function automatic fe_t rand_fe();
    int unsigned r;
    r = $random(seed);
    return fe_t'(r % P);
  endfunction

  function automatic fe_t add_mod(input fe_t a, input fe_t b);
    longint s;
    s = longint'(a) + longint'(b);
    return fe_t'(s % P);
  endfunction

  function automatic fe_t sub_mod(input fe_t a, input fe_t b);
    longint s;
    s = longint'(a) + longint'(P) - longint'(b);
    return fe_t'(s % P);
  endfunction

  function automatic fe_t mul_mod(input fe_t a, input fe_t b);
    longint s;
    s = longint'(a) * longint'(b);
    return fe_t'(s % P);
  endfunction

  function automatic fe_t header(input logic [7:0] tag, input logic [7:0] cnt);
    return (fe_t'(tag) << HDR_TAG_LSB) | (fe_t'(cnt) << HDR_CNT_LSB);
  endfunction

  task automatic step();
    @(posedge i_clk);
    #10;
  endtask

  task automatic load_inst(input inst_addr_t addr, input opcode_e op, input logic [7:0] a,
                           input logic [7:0] b, input logic [7:0] c);
    i_inst_we   = 1'b1;
    i_inst_addr = addr;
    i_inst_dat  = {op, a, b, c};
    step();
    i_inst_we   = 1'b0;
  endtask

  task automatic load_slot(input slot_addr_t addr, input fe_t dat);
    i_slot_we   = 1'b1;
    i_slot_addr = addr;
    i_slot_dat  = dat;
    step();
    i_slot_we   = 1'b0;
  endtask

  task automatic expect_word(input fe_t dat, input logic sop, input logic eop);
    exp_dat.push_back(dat);
    exp_sop.push_back(sop);
    exp_eop.push_back(eop);
  endtask

  // Pulses start and waits for the machine to halt and the last word to leave
  task automatic run_program(input inst_addr_t pt, input logic toggle_rdy, input string name);
    cur_test   = name;
    i_start    = 1'b1;
    i_start_pt = pt;
    step();
    i_start    = 1'b0;
    checks++;
    assert (o_busy) else begin
      $display("DUT did not go busy after the start pulse to address %0d", pt);
      errors++;
    end
    while (o_busy || o_tx_val) begin
      i_tx_rdy = toggle_rdy ? (($random(seed) & 1) != 0) : 1'b1;
      step();
    end
    i_tx_rdy = 1'b1;
  endtask

  task automatic check_packets();
    int n;
    n = (got_dat.size() < exp_dat.size()) ? got_dat.size() : exp_dat.size();
    checks++;
    assert (got_dat.size() == exp_dat.size()) else begin
      $display("FAILED %s word count: expected %0d, actual %0d", cur_test, exp_dat.size(),
               got_dat.size());
      errors++;
    end
    for (int i = 0; i < n; i++) begin
      checks++;
      assert (got_dat[i] == exp_dat[i] && got_sop[i] == exp_sop[i] && got_eop[i] == exp_eop[i])
      else begin
        $display("FAILED %s word %0d: expected sop %b eop %b %h, actual sop %b eop %b %h",
                 cur_test, i, exp_sop[i], exp_eop[i], exp_dat[i], got_sop[i], got_eop[i],
                 got_dat[i]);
        errors++;
      end
    end
  endtask

  task automatic clear_packets();
    got_dat.delete();
    got_sop.delete();
    got_eop.delete();
    exp_dat.delete();
    exp_sop.delete();
    exp_eop.delete();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
             WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    fe_t x;
    fe_t y;
    seed         = 52;
    checks       = 0;
    errors       = 0;
    cur_test     = "quiet";
    hold_pending = 1'b0;
    i_rst        = 1'b1;
    i_inst_we    = 1'b0;
    i_inst_addr  = '0;
    i_inst_dat   = '0;
    i_slot_we    = 1'b0;
    i_slot_addr  = '0;
    i_slot_dat   = '0;
    i_start      = 1'b0;
    i_start_pt   = '0;
    i_tx_rdy     = 1'b1;
    repeat (3) @(posedge i_clk);
    #10;
    i_rst = 1'b0;

    // Quiet before any start
    repeat (5) begin
      step();
      checks++;
      assert (!o_tx_val && !o_busy) else begin
        $display("Transmit valid or busy went high before any start pulse");
        errors++;
      end
    end

    load_inst(0, NOOP_WAIT, 0, 0, 0);
    run_program(0, 1'b0, "noop_only");
    check_packets();
    clear_packets();

    opnd[0] = rand_fe();
    load_slot(10, opnd[0]);
    load_inst(8, COPY_REG, 10, 11, 0);
    load_inst(9, SEND_INTERRUPT, 11, 8'h2a, 1);
    load_inst(10, NOOP_WAIT, 0, 0, 0);
    run_program(8, 1'b0, "copy_send");
    expect_word(header(8'h2a, 1), 1'b1, 1'b0);
    expect_word(opnd[0], 1'b0, 1'b1);
    check_packets();
    clear_packets();

    opnd[0] = rand_fe();
    opnd[1] = rand_fe();
    opnd[2] = fe_t'(P - 1);  // Sum needs the reduction
    opnd[3] = fe_t'(P - 2);
    x = rand_fe();
    y = rand_fe();
    opnd[4] = (x >= y) ? x : y;
    opnd[5] = (x >= y) ? y : x;
    x = rand_fe();
    y = rand_fe();
    if (x == y) begin
      y = fe_t'((x + 1) % P);
    end
    opnd[6] = (x < y) ? x : y;  // Subtraction wraps
    opnd[7] = (x < y) ? y : x;
    for (int i = 0; i < 8; i++) begin
      load_slot(slot_addr_t'(20 + i), opnd[i]);
    end
    load_inst(16, ADD_ELEMENT, 20, 21, 30);
    load_inst(17, ADD_ELEMENT, 22, 23, 31);
    load_inst(18, SUB_ELEMENT, 24, 25, 32);
    load_inst(19, SUB_ELEMENT, 26, 27, 33);
    load_inst(20, SEND_INTERRUPT, 30, 3, 4);
    load_inst(21, NOOP_WAIT, 0, 0, 0);
    run_program(16, 1'b0, "add_sub");
    expect_word(header(3, 4), 1'b1, 1'b0);
    expect_word(add_mod(opnd[0], opnd[1]), 1'b0, 1'b0);
    expect_word(add_mod(opnd[2], opnd[3]), 1'b0, 1'b0);
    expect_word(sub_mod(opnd[4], opnd[5]), 1'b0, 1'b0);
    expect_word(sub_mod(opnd[6], opnd[7]), 1'b0, 1'b1);
    check_packets();
    clear_packets();

    opnd[0] = rand_fe();
    opnd[1] = rand_fe();
    opnd[2] = '0;
    opnd[3] = rand_fe();
    opnd[4] = rand_fe();
    opnd[5] = fe_t'(1);
    opnd[6] = fe_t'(P - 1);
    opnd[7] = fe_t'(P - 1);
    for (int i = 0; i < 8; i++) begin
      load_slot(slot_addr_t'(40 + i), opnd[i]);
    end
    load_inst(24, MUL_ELEMENT, 40, 41, 50);
    load_inst(25, MUL_ELEMENT, 42, 43, 51);
    load_inst(26, MUL_ELEMENT, 44, 45, 52);
    load_inst(27, MUL_ELEMENT, 46, 47, 53);
    load_inst(28, SEND_INTERRUPT, 50, 4, 4);
    load_inst(29, NOOP_WAIT, 0, 0, 0);
    run_program(24, 1'b0, "mul");
    expect_word(header(4, 4), 1'b1, 1'b0);
    expect_word(mul_mod(opnd[0], opnd[1]), 1'b0, 1'b0);
    expect_word(mul_mod(opnd[2], opnd[3]), 1'b0, 1'b0);
    expect_word(mul_mod(opnd[4], opnd[5]), 1'b0, 1'b0);
    expect_word(mul_mod(opnd[6], opnd[7]), 1'b0, 1'b1);
    check_packets();
    clear_packets();

    // Long packet under random back-pressure
    for (int i = 0; i < 8; i++) begin
      opnd[i] = rand_fe();
      load_slot(slot_addr_t'(60 + i), opnd[i]);
    end
    load_inst(48, SEND_INTERRUPT, 60, 5, 8);
    load_inst(49, NOOP_WAIT, 0, 0, 0);
    run_program(48, 1'b1, "rdy_toggle");
    expect_word(header(5, 8), 1'b1, 1'b0);
    for (int i = 0; i < 8; i++) begin
      expect_word(opnd[i], 1'b0, i == 7);
    end
    check_packets();

    // Second start keeps the earlier packet in the queue ahead of the new one
    x = rand_fe();
    load_slot(70, x);
    load_inst(56, COPY_REG, 70, 71, 0);
    load_inst(57, SEND_INTERRUPT, 71, 6, 1);
    load_inst(58, NOOP_WAIT, 0, 0, 0);
    run_program(56, 1'b0, "restart");
    expect_word(header(6, 1), 1'b1, 1'b0);
    expect_word(x, 1'b0, 1'b1);
    check_packets();
    clear_packets();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
